/* Makefile */
TOP := tb_mcr3_ctrl
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* analog_source_select.sv */
// Follows whichever source moved last; if both move on one edge, source 1 wins
`timescale 1ns/1ns

module analog_source_select (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  mcr3_ctrl_pkg::analog_t  src0,
	input  mcr3_ctrl_pkg::analog_t  src1,
	output mcr3_ctrl_pkg::analog_t  value
);

	mcr3_ctrl_pkg::analog_t src0_q;
	mcr3_ctrl_pkg::analog_t src1_q;
	logic                   sel;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			src0_q <= '0;
			src1_q <= '0;
			sel    <= 1'b0;
			value  <= '0;
		end else begin
			src0_q <= src0;
			src1_q <= src1;
			// Movement detection against the previous sample
			if (src1_q != src1) begin
				sel <= 1'b1;
			end else if (src0_q != src0) begin
				sel <= 1'b0;
			end
			// Output taken from the registered copies, two edges behind the input
			value <= sel ? src1_q : src0_q;
		end
	end

endmodule

/* boot_sequencer.sv */
// Game stays in reset until a ROM download has completed; reset_req is honoured only in run
`timescale 1ns/1ns

module boot_sequencer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ioctl_download,
	input  mcr3_ctrl_pkg::dl_index_t  ioctl_index,
	input  logic                      reset_req,
	input  logic                      hold_done,
	output logic                      hold_start,
	output logic                      game_reset,
	output logic                      rom_loading,
	output mcr3_ctrl_pkg::boot_state_t state
);

	logic                       rom_download;
	logic                       rom_download_q;
	logic                       hold_start_next;
	mcr3_ctrl_pkg::boot_state_t state_next;

	// Only index 0 carries the game ROM
	assign rom_download = ioctl_download && (ioctl_index == mcr3_ctrl_pkg::dl_index_rom);

	always_comb begin
		state_next      = state;
		hold_start_next = 1'b0;
		case (state)
			mcr3_ctrl_pkg::wait_rom: begin
				if (rom_download) state_next = mcr3_ctrl_pkg::loading;
			end
			mcr3_ctrl_pkg::loading: begin
				// Falling edge of the download starts the hold
				if (rom_download_q && !rom_download) begin
					state_next      = mcr3_ctrl_pkg::hold;
					hold_start_next = 1'b1;
				end
			end
			mcr3_ctrl_pkg::hold: begin
				if (rom_download) begin
					state_next = mcr3_ctrl_pkg::loading;
				end else if (hold_done && !hold_start) begin
					state_next = mcr3_ctrl_pkg::run;
				end
			end
			default: begin
				if (rom_download) begin
					state_next = mcr3_ctrl_pkg::loading;
				end else if (reset_req) begin
					state_next      = mcr3_ctrl_pkg::hold;
					hold_start_next = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state          <= mcr3_ctrl_pkg::wait_rom;
			rom_download_q <= 1'b0;
			hold_start     <= 1'b0;
		end else begin
			state          <= state_next;
			rom_download_q <= rom_download;
			hold_start     <= hold_start_next;
		end
	end

	assign game_reset  = (state != mcr3_ctrl_pkg::run);
	assign rom_loading = (state == mcr3_ctrl_pkg::loading);

endmodule

/* download_config.sv */
// Variant byte and DIP banks come from host writes; only bank 0 and the service bit are exported
`timescale 1ns/1ns

module download_config (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  logic                          ioctl_wr,
	input  mcr3_ctrl_pkg::dl_index_t      ioctl_index,
	input  mcr3_ctrl_pkg::dl_addr_t       ioctl_addr,
	input  mcr3_ctrl_pkg::byte_t          ioctl_dout,
	output mcr3_ctrl_pkg::game_variant_t  variant,
	output mcr3_ctrl_pkg::byte_t          dip0,
	output logic                          service
);

	mcr3_ctrl_pkg::byte_t variant_byte;
	mcr3_ctrl_pkg::byte_t dip [8];

	logic variant_wr;
	logic dip_wr;

	assign variant_wr = ioctl_wr && (ioctl_index == mcr3_ctrl_pkg::dl_index_variant);
	// DIP file is eight bytes long, anything above is ignored
	assign dip_wr     = ioctl_wr && (ioctl_index == mcr3_ctrl_pkg::dl_index_dip) &&
	                    (ioctl_addr[24:3] == '0);

	// ================================================
	// Game variant, stored then decoded
	// ================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			variant_byte <= '0;
			variant      <= mcr3_ctrl_pkg::spy_hunter;
		end else begin
			if (variant_wr) variant_byte <= ioctl_dout;
			case (variant_byte)
				8'd0:    variant <= mcr3_ctrl_pkg::spy_hunter;
				8'd1:    variant <= mcr3_ctrl_pkg::turbo_tag;
				8'd2:    variant <= mcr3_ctrl_pkg::crater;
				default: variant <= mcr3_ctrl_pkg::other;
			endcase
		end
	end

	// ================================================
	// DIP switch banks
	// ================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				dip[i] <= '0;
			end
		end else if (dip_wr) begin
			dip[ioctl_addr[2:0]] <= ioctl_dout;
		end
	end

	assign dip0    = dip[0];
	assign service = dip[1][0];   // bank 1 bit 0 is the service switch

endmodule

/* filelist.f */
mcr3_ctrl_pkg.sv
boot_sequencer.sv
reset_hold_timer.sv
download_config.sv
analog_source_select.sv
game_input_mapper.sv
mcr3_ctrl_top.sv
tb_clock_gen.sv
mcr3_ctrl_assert.sv
tb_mcr3_ctrl.sv

/* game_input_mapper.sv */
// Active-low input ports per variant; steering and gas come from paddle and stick only, no emulation
`timescale 1ns/1ns

module game_input_mapper (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  mcr3_ctrl_pkg::game_variant_t  variant,
	input  mcr3_ctrl_pkg::byte_t          dip0,
	input  logic                          service,
	input  mcr3_ctrl_pkg::buttons_t       joy1,
	input  mcr3_ctrl_pkg::buttons_t       joy2,
	input  mcr3_ctrl_pkg::analog_t        spin,
	input  mcr3_ctrl_pkg::analog_t        paddle,
	input  mcr3_ctrl_pkg::byte_t          analog_y,
	input  logic                          lamp_select,
	output mcr3_ctrl_pkg::byte_t          in_port0,
	output mcr3_ctrl_pkg::byte_t          in_port1,
	output mcr3_ctrl_pkg::byte_t          in_port2,
	output mcr3_ctrl_pkg::byte_t          in_port3,
	output mcr3_ctrl_pkg::byte_t          in_port4,
	output logic                          landscape
);

	mcr3_ctrl_pkg::buttons_t btn;
	mcr3_ctrl_pkg::byte_t    steer;
	mcr3_ctrl_pkg::byte_t    gas_g;
	mcr3_ctrl_pkg::byte_t    gas;
	mcr3_ctrl_pkg::byte_t    port0_next;
	mcr3_ctrl_pkg::byte_t    port1_next;
	mcr3_ctrl_pkg::byte_t    port2_next;
	logic                    landscape_next;
	logic                    y_negative;

	// Both players share one set of cabinet controls
	assign btn = joy1 | joy2;

	// ================================================
	// Steering and gas bytes
	// ================================================

	assign steer = mcr3_ctrl_pkg::steer_center +
	               {~paddle[7], ~paddle[7], paddle[6:1]};

	assign y_negative = analog_y[7];
	always_comb begin
		if (y_negative) begin
			gas_g = 8'h00 - analog_y;
		end else if (variant == mcr3_ctrl_pkg::turbo_tag) begin
			gas_g = analog_y;
		end else begin
			gas_g = 8'h00;
		end
	end
	assign gas = {gas_g[6:0], 1'b1};

	// ================================================
	// Port mapping
	// ================================================

	always_comb begin
		port0_next     = mcr3_ctrl_pkg::port_idle;
		port1_next     = mcr3_ctrl_pkg::port_idle;
		port2_next     = mcr3_ctrl_pkg::port_idle;
		landscape_next = 1'b0;
		case (variant)
			mcr3_ctrl_pkg::spy_hunter: begin
				port0_next = ~{service, 2'b00, btn[mcr3_ctrl_pkg::btn_shift], 3'b000,
				               btn[mcr3_ctrl_pkg::btn_coin]};
				port1_next = ~{3'b000, btn[mcr3_ctrl_pkg::btn_fire_a],
				               btn[mcr3_ctrl_pkg::btn_fire_c], btn[mcr3_ctrl_pkg::btn_fire_e],
				               btn[mcr3_ctrl_pkg::btn_fire_b], btn[mcr3_ctrl_pkg::btn_fire_d]};
				port2_next = lamp_select ? steer : gas;
			end
			mcr3_ctrl_pkg::turbo_tag: begin
				// Pulling the stick back also acts as shift
				port0_next = ~{service, 2'b00, btn[mcr3_ctrl_pkg::btn_shift] | y_negative,
				               3'b000, btn[mcr3_ctrl_pkg::btn_coin]};
				port1_next = ~{3'b000, btn[mcr3_ctrl_pkg::btn_fire_e:mcr3_ctrl_pkg::btn_fire_a]};
				port2_next = lamp_select ? steer : gas;
			end
			mcr3_ctrl_pkg::crater: begin
				port0_next = ~{service, 2'b00, btn[mcr3_ctrl_pkg::btn_fire_a],
				               btn[mcr3_ctrl_pkg::btn_fire_e], btn[mcr3_ctrl_pkg::btn_shift],
				               1'b0, btn[mcr3_ctrl_pkg::btn_coin]};
				port1_next = spin[7:0];   // spinner position, not inverted
				port2_next = ~{1'b0, btn[mcr3_ctrl_pkg::btn_fire_b], 1'b0,
				               btn[mcr3_ctrl_pkg::btn_fire_c], btn[mcr3_ctrl_pkg::btn_down],
				               btn[mcr3_ctrl_pkg::btn_up], 2'b00};
				landscape_next = 1'b1;
			end
			default: begin
				landscape_next = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			in_port0  <= mcr3_ctrl_pkg::port_idle;
			in_port1  <= mcr3_ctrl_pkg::port_idle;
			in_port2  <= mcr3_ctrl_pkg::port_idle;
			in_port3  <= mcr3_ctrl_pkg::port_idle;
			in_port4  <= mcr3_ctrl_pkg::port_idle;
			landscape <= 1'b0;
		end else begin
			in_port0  <= port0_next;
			in_port1  <= port1_next;
			in_port2  <= port2_next;
			in_port3  <= dip0;
			in_port4  <= mcr3_ctrl_pkg::port_idle;
			landscape <= landscape_next;
		end
	end

endmodule

/* mcr3_ctrl_assert.sv */
// Bound into mcr3_ctrl_top; checks are idle while arst_n is low, fail_count tallies failures
`timescale 1ns/1ns

module mcr3_ctrl_assert (
	input logic                        clk_sys,
	input logic                        arst_n,
	input logic                        hold_start,
	input logic                        game_reset,
	input mcr3_ctrl_pkg::boot_state_t  state,
	input mcr3_ctrl_pkg::byte_t        in_port4
);

	int unsigned fail_count = 0;

	// Start of the hold is a single-cycle pulse
	hold_start_single: assert property (
		@(posedge clk_sys) disable iff (!arst_n) hold_start |=> !hold_start
	) else begin
		fail_count++;
		$error("hold_start high on two consecutive edges");
	end

	// Game must stay in reset outside the run state
	reset_outside_run: assert property (
		@(posedge clk_sys) disable iff (!arst_n) (state != mcr3_ctrl_pkg::run) |-> game_reset
	) else begin
		fail_count++;
		$error("game_reset low while the boot FSM is not in run");
	end

	port4_idle: assert property (
		@(posedge clk_sys) disable iff (!arst_n) in_port4 == mcr3_ctrl_pkg::port_idle
	) else begin
		fail_count++;
		$error("in_port4 left its idle value");
	end

endmodule

bind mcr3_ctrl_top mcr3_ctrl_assert u_ctrl_assert (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.hold_start (hold_start),
	.game_reset (game_reset),
	.state      (boot_state),
	.in_port4   (in_port4)
);

/* mcr3_ctrl_pkg.sv */
// Shared widths, constants and FSM types; the reset hold is shortened to 64 cycles for simulation
package mcr3_ctrl_pkg;

	// ================================================
	// Constants
	// ================================================

	// Download indices used by the host loader
	localparam logic [7:0] dl_index_rom     = 8'd0;
	localparam logic [7:0] dl_index_variant = 8'd1;
	localparam logic [7:0] dl_index_dip     = 8'd254;

	// Game held in reset this many cycles after load or reset request
	localparam int reset_hold_cycles = 64;

	// Steering byte offset and the idle value of an active-low port
	localparam logic [7:0] steer_center = 8'h70;
	localparam logic [7:0] port_idle    = 8'hff;

	// Bit positions inside one player's button word
	localparam int btn_right  = 0;
	localparam int btn_left   = 1;
	localparam int btn_down   = 2;
	localparam int btn_up     = 3;
	localparam int btn_fire_a = 4;
	localparam int btn_fire_b = 5;
	localparam int btn_fire_c = 6;
	localparam int btn_fire_d = 7;
	localparam int btn_fire_e = 8;
	localparam int btn_shift  = 9;
	localparam int btn_coin   = 10;

	// ================================================
	// Types
	// ================================================

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [8:0]  analog_t;
	typedef logic [11:0] buttons_t;
	typedef logic [$clog2(reset_hold_cycles + 1) - 1:0] hold_count_t;

	typedef enum logic [1:0] {
		wait_rom = 2'd0,
		loading  = 2'd1,
		hold     = 2'd2,
		run      = 2'd3
	} boot_state_t;

	typedef enum logic [1:0] {
		spy_hunter = 2'd0,
		turbo_tag  = 2'd1,
		crater     = 2'd2,
		other      = 2'd3
	} game_variant_t;

endpackage

/* mcr3_ctrl_top.sv */
// Control side only: no video, audio or SDRAM; one analog stick feeds gas and turbo_tag shift
`timescale 1ns/1ns

module mcr3_ctrl_top (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  mcr3_ctrl_pkg::dl_index_t  ioctl_index,
	input  mcr3_ctrl_pkg::dl_addr_t   ioctl_addr,
	input  mcr3_ctrl_pkg::byte_t      ioctl_dout,
	input  logic                      reset_req,
	input  mcr3_ctrl_pkg::buttons_t   joy1,
	input  mcr3_ctrl_pkg::buttons_t   joy2,
	input  mcr3_ctrl_pkg::analog_t    spin1,
	input  mcr3_ctrl_pkg::analog_t    spin2,
	input  mcr3_ctrl_pkg::byte_t      pad1,
	input  mcr3_ctrl_pkg::byte_t      pad2,
	input  mcr3_ctrl_pkg::byte_t      analog_y,
	input  logic                      lamp_select,
	output logic                      game_reset,
	output logic                      rom_loading,
	output mcr3_ctrl_pkg::byte_t      in_port0,
	output mcr3_ctrl_pkg::byte_t      in_port1,
	output mcr3_ctrl_pkg::byte_t      in_port2,
	output mcr3_ctrl_pkg::byte_t      in_port3,
	output mcr3_ctrl_pkg::byte_t      in_port4,
	output logic                      landscape
);

	logic                          hold_start;
	logic                          hold_done;
	mcr3_ctrl_pkg::boot_state_t    boot_state;
	mcr3_ctrl_pkg::game_variant_t  variant;
	mcr3_ctrl_pkg::byte_t          dip0;
	logic                          service;
	mcr3_ctrl_pkg::analog_t        spin;
	mcr3_ctrl_pkg::analog_t        paddle;

	// ================================================
	// Boot and reset
	// ================================================

	boot_sequencer u_boot_sequencer (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.reset_req      (reset_req),
		.hold_done      (hold_done),
		.hold_start     (hold_start),
		.game_reset     (game_reset),
		.rom_loading    (rom_loading),
		.state          (boot_state)
	);

	reset_hold_timer u_reset_hold_timer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.hold_start (hold_start),
		.hold_done  (hold_done)
	);

	download_config u_download_config (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.variant     (variant),
		.dip0        (dip0),
		.service     (service)
	);

	// ================================================
	// Controls
	// ================================================

	analog_source_select u_spin_select (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.src0    (spin1),
		.src1    (spin2),
		.value   (spin)
	);

	// Paddles are 8 bit, widened with a zero top bit
	analog_source_select u_paddle_select (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.src0    ({1'b0, pad1}),
		.src1    ({1'b0, pad2}),
		.value   (paddle)
	);

	game_input_mapper u_game_input_mapper (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.variant     (variant),
		.dip0        (dip0),
		.service     (service),
		.joy1        (joy1),
		.joy2        (joy2),
		.spin        (spin),
		.paddle      (paddle),
		.analog_y    (analog_y),
		.lamp_select (lamp_select),
		.in_port0    (in_port0),
		.in_port1    (in_port1),
		.in_port2    (in_port2),
		.in_port3    (in_port3),
		.in_port4    (in_port4),
		.landscape   (landscape)
	);

endmodule

/* reset_hold_timer.sv */
// One-shot hold timer; hold_done pulses reset_hold_cycles edges after the edge that sees hold_start
`timescale 1ns/1ns

module reset_hold_timer (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic hold_start,
	output logic hold_done
);

	mcr3_ctrl_pkg::hold_count_t count;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			count     <= '0;
			hold_done <= 1'b0;
		end else if (hold_start) begin
			// A new start always reloads, even mid count
			count     <= mcr3_ctrl_pkg::hold_count_t'(mcr3_ctrl_pkg::reset_hold_cycles);
			hold_done <= 1'b0;
		end else if (count != '0) begin
			count     <= count - 1'b1;
			hold_done <= (count == mcr3_ctrl_pkg::hold_count_t'(1));
		end else begin
			hold_done <= 1'b0;
		end
	end

endmodule

/* tb_clock_gen.sv */
// Testbench clock of 40 ns period; arst_n is released 5 ns after the 16th rising edge
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	localparam int half_period_ns = 20;
	localparam int reset_cycles   = 16;

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(half_period_ns) clk_sys = ~clk_sys;
		end
	end

	// Release off the edge so the first sampled edge sees a clean level
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		#5;
		arst_n = 1'b1;
	end

endmodule

/* tb_mcr3_ctrl.sv */
// Needs the bound assertion module; expected ports come from the mapping rules, 4 edges per row
`timescale 1ns/1ns

module tb_mcr3_ctrl;

	localparam int num_rows        = 24;
	localparam int settle_edges    = 4;
	localparam int hold_edges      = mcr3_ctrl_pkg::reset_hold_cycles + 2;
	localparam int watchdog_cycles = num_rows * 8 + 200;

	typedef struct {
		string                   name;
		logic [7:0]              variant_byte;
		logic                    service;
		logic                    lamp;
		mcr3_ctrl_pkg::buttons_t joy1;
		mcr3_ctrl_pkg::buttons_t joy2;
		mcr3_ctrl_pkg::analog_t  spin;
		mcr3_ctrl_pkg::byte_t    pad;
		mcr3_ctrl_pkg::byte_t    y;
		mcr3_ctrl_pkg::byte_t    exp_port0;
		mcr3_ctrl_pkg::byte_t    exp_port1;
		mcr3_ctrl_pkg::byte_t    exp_port2;
		logic                    exp_landscape;
	} row_t;

	logic                      clk_sys;
	logic                      arst_n;
	logic                      ioctl_download;
	logic                      ioctl_wr;
	mcr3_ctrl_pkg::dl_index_t  ioctl_index;
	mcr3_ctrl_pkg::dl_addr_t   ioctl_addr;
	mcr3_ctrl_pkg::byte_t      ioctl_dout;
	logic                      reset_req;
	mcr3_ctrl_pkg::buttons_t   joy1;
	mcr3_ctrl_pkg::buttons_t   joy2;
	mcr3_ctrl_pkg::analog_t    spin1;
	mcr3_ctrl_pkg::analog_t    spin2;
	mcr3_ctrl_pkg::byte_t      pad1;
	mcr3_ctrl_pkg::byte_t      pad2;
	mcr3_ctrl_pkg::byte_t      analog_y;
	logic                      lamp_select;
	logic                      game_reset;
	logic                      rom_loading;
	mcr3_ctrl_pkg::byte_t      in_port0;
	mcr3_ctrl_pkg::byte_t      in_port1;
	mcr3_ctrl_pkg::byte_t      in_port2;
	mcr3_ctrl_pkg::byte_t      in_port3;
	mcr3_ctrl_pkg::byte_t      in_port4;
	logic                      landscape;

	row_t        table_rows [num_rows];
	logic [31:0] lfsr_state;
	int          tests_run;
	int          tests_failed;
	logic [7:0]  cur_variant;
	logic        cur_service;

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	mcr3_ctrl_top DUT (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.joy1           (joy1),
		.joy2           (joy2),
		.spin1          (spin1),
		.spin2          (spin2),
		.pad1           (pad1),
		.pad2           (pad2),
		.analog_y       (analog_y),
		.lamp_select    (lamp_select),
		.game_reset     (game_reset),
		.rom_loading    (rom_loading),
		.in_port0       (in_port0),
		.in_port1       (in_port1),
		.in_port2       (in_port2),
		.in_port3       (in_port3),
		.in_port4       (in_port4),
		.landscape      (landscape)
	);

	// ================================================
	// Stimulus and reference model
	// ================================================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic mcr3_ctrl_pkg::byte_t steer_byte(input mcr3_ctrl_pkg::byte_t pad);
		mcr3_ctrl_pkg::byte_t raw;
		raw = {~pad[7], ~pad[7], pad[6:1]};
		return raw + mcr3_ctrl_pkg::steer_center;
	endfunction

	function automatic mcr3_ctrl_pkg::byte_t gas_byte(input mcr3_ctrl_pkg::byte_t y,
	                                                  input logic turbo);
		mcr3_ctrl_pkg::byte_t g;
		g = 8'h00;
		if (y[7]) begin
			g = ~y + 8'd1;
		end else if (turbo) begin
			g = y;
		end
		return {g[6:0], 1'b1};
	endfunction

	function automatic row_t add_expected(input row_t r);
		mcr3_ctrl_pkg::buttons_t btn;
		row_t                    e;
		e               = r;
		btn             = r.joy1 | r.joy2;
		e.exp_port0     = mcr3_ctrl_pkg::port_idle;
		e.exp_port1     = mcr3_ctrl_pkg::port_idle;
		e.exp_port2     = mcr3_ctrl_pkg::port_idle;
		e.exp_landscape = 1'b0;
		case (r.variant_byte)
			8'd0, 8'd1: begin
				e.exp_port0[0] = ~btn[mcr3_ctrl_pkg::btn_coin];
				e.exp_port0[4] = ~(btn[mcr3_ctrl_pkg::btn_shift] |
				                   (r.variant_byte == 8'd1 && r.y[7]));
				e.exp_port0[7] = ~r.service;
				if (r.variant_byte == 8'd0) begin
					e.exp_port1[0] = ~btn[mcr3_ctrl_pkg::btn_fire_d];
					e.exp_port1[1] = ~btn[mcr3_ctrl_pkg::btn_fire_b];
					e.exp_port1[2] = ~btn[mcr3_ctrl_pkg::btn_fire_e];
					e.exp_port1[3] = ~btn[mcr3_ctrl_pkg::btn_fire_c];
					e.exp_port1[4] = ~btn[mcr3_ctrl_pkg::btn_fire_a];
				end else begin
					for (int k = 0; k < 5; k++) begin
						e.exp_port1[k] = ~btn[mcr3_ctrl_pkg::btn_fire_a + k];
					end
				end
				e.exp_port2 = r.lamp ? steer_byte(r.pad) : gas_byte(r.y, r.variant_byte == 8'd1);
			end
			8'd2: begin
				e.exp_port0[0] = ~btn[mcr3_ctrl_pkg::btn_coin];
				e.exp_port0[2] = ~btn[mcr3_ctrl_pkg::btn_shift];
				e.exp_port0[3] = ~btn[mcr3_ctrl_pkg::btn_fire_e];
				e.exp_port0[4] = ~btn[mcr3_ctrl_pkg::btn_fire_a];
				e.exp_port0[7] = ~r.service;
				e.exp_port1    = r.spin[7:0];
				e.exp_port2[2] = ~btn[mcr3_ctrl_pkg::btn_up];
				e.exp_port2[3] = ~btn[mcr3_ctrl_pkg::btn_down];
				e.exp_port2[4] = ~btn[mcr3_ctrl_pkg::btn_fire_c];
				e.exp_port2[6] = ~btn[mcr3_ctrl_pkg::btn_fire_b];
				e.exp_landscape = 1'b1;
			end
			default: begin
			end
		endcase
		return e;
	endfunction

	// Six rows per variant cover both lamp_select levels, both stick signs and service
	function automatic row_t make_row(input int i);
		row_t r;
		int   j;
		j              = i % 6;
		r.name         = $sformatf("row%0d", i);
		r.variant_byte = 8'(i / 6);
		r.lamp         = (j < 2);
		r.service      = j[1];
		r.joy1         = 12'(random_bits(12));
		r.joy2         = 12'(random_bits(12) & random_bits(12));
		r.spin         = 9'(random_bits(9));
		r.pad          = 8'(random_bits(8));
		r.y            = {j[0], 7'(random_bits(7))};
		return add_expected(r);
	endfunction

	// ================================================
	// Drivers and checks
	// ================================================

	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic settle();
		repeat (settle_edges) next_cycle();
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
	                           input logic [15:0] actual);
		tests_run++;
		assert (actual === expected) begin
			$display("[OK] %s = %h", name, actual);
		end else begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			tests_failed++;
		end
	endtask

	task automatic write_config(input mcr3_ctrl_pkg::dl_index_t index,
	                            input mcr3_ctrl_pkg::dl_addr_t addr,
	                            input mcr3_ctrl_pkg::byte_t data);
		ioctl_download = 1'b1;
		ioctl_index    = index;
		ioctl_addr     = addr;
		ioctl_dout     = data;
		ioctl_wr       = 1'b1;
		next_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
	endtask

	// Counts edges after the one that started the hold until the game runs
	task automatic measure_hold(input string name);
		int edges;
		edges = 0;
		while (game_reset === 1'b1 && edges < 2 * hold_edges) begin
			next_cycle();
			edges++;
		end
		assert (game_reset === 1'b0) else begin
			$display("%s: game_reset still high after %0d edges", name, edges);
			tests_run++;
			tests_failed++;
		end
		if (game_reset === 1'b0) begin
			check_value(name, 16'(hold_edges), 16'(edges));
		end
	endtask

	task automatic apply_row(input row_t r);
		if (r.variant_byte != cur_variant) begin
			write_config(mcr3_ctrl_pkg::dl_index_variant, 25'd0, r.variant_byte);
			cur_variant = r.variant_byte;
		end
		if (r.service != cur_service) begin
			write_config(mcr3_ctrl_pkg::dl_index_dip, 25'd1, {7'd0, r.service});
			cur_service = r.service;
		end
		joy1        = r.joy1;
		joy2        = r.joy2;
		spin1       = r.spin;
		pad1        = r.pad;
		analog_y    = r.y;
		lamp_select = r.lamp;
		settle();
		check_value({r.name, " in_port0"}, 16'(r.exp_port0), 16'(in_port0));
		check_value({r.name, " in_port1"}, 16'(r.exp_port1), 16'(in_port1));
		check_value({r.name, " in_port2"}, 16'(r.exp_port2), 16'(in_port2));
		check_value({r.name, " landscape"}, 16'(r.exp_landscape), 16'(landscape));
	endtask

	// ================================================
	// Test sequence
	// ================================================

	initial begin
		mcr3_ctrl_pkg::byte_t   dip_bank0;
		int                     edges;
		int unsigned            assert_fails;
		lfsr_state     = 32'hd403_c2c4;
		tests_run      = 0;
		tests_failed   = 0;
		cur_variant    = 8'd0;
		cur_service    = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		joy1           = '0;
		joy2           = '0;
		spin1          = '0;
		spin2          = '0;
		pad1           = '0;
		pad2           = '0;
		analog_y       = '0;
		lamp_select    = 1'b0;
		for (int i = 0; i < num_rows; i++) begin
			table_rows[i] = make_row(i);
		end

		wait (arst_n === 1'b1);
		check_value("reset game_reset", 16'd1, 16'(game_reset));
		check_value("reset in_port0", 16'(mcr3_ctrl_pkg::port_idle), 16'(in_port0));
		check_value("reset in_port1", 16'(mcr3_ctrl_pkg::port_idle), 16'(in_port1));
		check_value("reset in_port2", 16'(mcr3_ctrl_pkg::port_idle), 16'(in_port2));
		check_value("reset in_port3", 16'(mcr3_ctrl_pkg::port_idle), 16'(in_port3));
		check_value("reset in_port4", 16'(mcr3_ctrl_pkg::port_idle), 16'(in_port4));

		// ROM download of 16 bytes, then the hold
		ioctl_download = 1'b1;
		ioctl_index    = mcr3_ctrl_pkg::dl_index_rom;
		edges          = 0;
		while (rom_loading !== 1'b1 && edges < 8) begin
			next_cycle();
			edges++;
		end
		assert (rom_loading === 1'b1) begin
			$display("[OK] rom_loading rose %0d edge(s) after the download start", edges);
			tests_run++;
		end else begin
			$display("rom_loading did not rise within %0d edges of the download start", edges);
			tests_run++;
			tests_failed++;
		end
		for (int i = 0; i < 16; i++) begin
			ioctl_addr = 25'(i);
			ioctl_dout = 8'(random_bits(8));
			ioctl_wr   = 1'b1;
			next_cycle();
		end
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		next_cycle();
		measure_hold("boot hold edges");

		// External reset request while running
		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		check_value("reset_req game_reset", 16'd1, 16'(game_reset));
		measure_hold("reset_req hold edges");

		// DIP banks and the service switch
		dip_bank0 = 8'(random_bits(8));
		write_config(mcr3_ctrl_pkg::dl_index_dip, 25'd0, dip_bank0);
		write_config(mcr3_ctrl_pkg::dl_index_dip, 25'd1, 8'h01);
		settle();
		check_value("dip bank0 in_port3", 16'(dip_bank0), 16'(in_port3));
		check_value("service on in_port0 bit7", 16'd0, 16'(in_port0[7]));
		write_config(mcr3_ctrl_pkg::dl_index_dip, 25'd1, 8'h00);
		settle();
		check_value("service off in_port0 bit7", 16'd1, 16'(in_port0[7]));

		for (int i = 0; i < num_rows; i++) begin
			apply_row(table_rows[i]);
		end

		// Last-moved spinner in crater, bit 0 flip keeps each step visible
		write_config(mcr3_ctrl_pkg::dl_index_variant, 25'd0, 8'd2);
		settle();
		spin2 = spin1 ^ {1'b0, 7'(random_bits(7)), 1'b1};
		settle();
		check_value("spin2 moved in_port1", 16'(spin2[7:0]), 16'(in_port1));
		spin1 = spin2 ^ {1'b0, 7'(random_bits(7)), 1'b1};
		settle();
		check_value("spin1 moved in_port1", 16'(spin1[7:0]), 16'(in_port1));

		// Last-moved paddle through the steering byte, bit 1 is its lowest visible bit
		write_config(mcr3_ctrl_pkg::dl_index_variant, 25'd0, 8'd0);
		lamp_select = 1'b1;
		settle();
		pad2 = pad1 ^ {6'(random_bits(6)), 2'b10};
		settle();
		check_value("pad2 moved in_port2", 16'(steer_byte(pad2)), 16'(in_port2));
		pad1 = pad2 ^ {6'(random_bits(6)), 2'b10};
		settle();
		check_value("pad1 moved in_port2", 16'(steer_byte(pad1)), 16'(in_port2));

		assert_fails = DUT.u_ctrl_assert.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d assertion failures",
		         tests_run, tests_failed, assert_fails);
		if (tests_failed == 0 && assert_fails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Bounds the run by the table length plus the boot and hold phases
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule
